//--- include/aes_key_consts.svh
// Fixed sizes of the AES key schedule engine
// Word and window widths, step counter width, step limits, Rcon start values

`ifndef AES_KEY_CONSTS_SVH
`define AES_KEY_CONSTS_SVH

// One schedule word and the held key window
`define AES_WORD_W 32
`define AES_KEY_WORDS 8

// Step counter width, wide enough for 13
`define AES_ROUND_W 4

// Expansion steps per key length
`define AES_STEPS_128 10
`define AES_STEPS_256 13

// Rcon start values
// forward always begins at 01, inverse at the last Rcon used
`define AES_RCON_FWD_INIT 8'h01
`define AES_RCON_INV_128 8'h36
`define AES_RCON_INV_256 8'h40

`endif

//--- rtl/aes_key_pkg.sv
// Shared types of the AES key schedule engine
// Direction, key length and controller state enums, key word union

`include "aes_key_consts.svh"

package aes_key_pkg;

  // Direction of the expansion
  typedef enum logic {
    CIPH_FWD = 1'b0,
    CIPH_INV = 1'b1
  } ciph_op_e;

  // Key length
  // 2'b01 was AES-192 and is invalid here
  typedef enum logic [1:0] {
    AES_128 = 2'b00,
    AES_256 = 2'b10
  } key_len_e;

  // Controller state
  typedef enum logic {
    KEY_IDLE   = 1'b0,
    KEY_ACTIVE = 1'b1
  } key_ctrl_state_e;

  // One schedule word
  // XORed as a whole word, substituted byte by byte; b[3] is the FIPS first byte
  typedef union packed {
    logic [`AES_WORD_W-1:0] w;
    logic [3:0][7:0]        b;
  } key_word_u;

endpackage

//--- rtl/aes_sbox_lut.sv
// Forward AES S-Box for a single byte
// Upper nibble picks a table row, lower nibble picks the byte inside it

`timescale 1ns/1ps

module aes_sbox_lut (
  input  logic [7:0] data_i,
  output logic [7:0] data_o
);

  // One row of 16 substituted bytes, entry 0 in the top byte
  logic [127:0] row;
  logic [3:0]   col;

  assign col = data_i[3:0];

  ////////////////////
  // Table rows
  ////////////////////

  always_comb begin
    unique case (data_i[7:4])
      4'h0: row = 128'h637c777bf26b6fc53001672bfed7ab76;
      4'h1: row = 128'hca82c97dfa5947f0add4a2af9ca472c0;
      4'h2: row = 128'hb7fd9326363ff7cc34a5e5f171d83115;
      4'h3: row = 128'h04c723c31896059a071280e2eb27b275;
      4'h4: row = 128'h09832c1a1b6e5aa0523bd6b329e32f84;
      4'h5: row = 128'h53d100ed20fcb15b6acbbe394a4c58cf;
      4'h6: row = 128'hd0efaafb434d338545f9027f503c9fa8;
      4'h7: row = 128'h51a3408f929d38f5bcb6da2110fff3d2;
      4'h8: row = 128'hcd0c13ec5f974417c4a77e3d645d1973;
      4'h9: row = 128'h60814fdc222a908846eeb814de5e0bdb;
      4'ha: row = 128'he0323a0a4906245cc2d3ac629195e479;
      4'hb: row = 128'he7c8376d8dd54ea96c56f4ea657aae08;
      4'hc: row = 128'hba78252e1ca6b4c6e8dd741f4bbd8b8a;
      4'hd: row = 128'h703eb5664803f60e613557b986c11d9e;
      4'he: row = 128'he1f8981169d98e949b1e87e9ce5528df;
      4'hf: row = 128'h8ca1890dbfe6426841992d0fb054bb16;
      default: row = '0;
    endcase
  end

  // Column 0 sits in bits 127:120
  assign data_o = row[8*(15-col) +: 8];

endmodule

//--- rtl/aes_rcon_gen.sv
// Rcon register of the key schedule
// Start value per direction and key length, GF(2^8) times or divided by two

`timescale 1ns/1ps
`include "aes_key_consts.svh"

module aes_rcon_gen (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   init_i,
  input  logic                   adv_i,
  input  aes_key_pkg::ciph_op_e  op_i,
  input  aes_key_pkg::key_len_e  key_len_i,
  output logic [7:0]             rcon_o
);

  logic [7:0] rcon_q;
  logic [7:0] rcon_init;
  logic [7:0] rcon_mul2;
  logic [7:0] rcon_div2;

  // Inverse runs start from the last Rcon the forward run used
  always_comb begin
    if (op_i == aes_key_pkg::CIPH_FWD) begin
      rcon_init = `AES_RCON_FWD_INIT;
    end else if (key_len_i == aes_key_pkg::AES_256) begin
      rcon_init = `AES_RCON_INV_256;
    end else begin
      rcon_init = `AES_RCON_INV_128;
    end
  end

  // xtime, reduced by the AES polynomial
  assign rcon_mul2 = {rcon_q[6:0], 1'b0} ^ (rcon_q[7] ? 8'h1b : 8'h00);
  // Inverse of xtime, odd values had been reduced
  assign rcon_div2 = {1'b0, rcon_q[7:1]} ^ (rcon_q[0] ? 8'h8d : 8'h00);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rcon_q <= '0;
    end else if (init_i) begin
      rcon_q <= rcon_init;
    end else if (adv_i) begin
      rcon_q <= (op_i == aes_key_pkg::CIPH_FWD) ? rcon_mul2 : rcon_div2;
    end
  end

  assign rcon_o = rcon_q;

  // Powers of two in GF(2^8) never reach zero
  // An advance without a prior load would stay at zero
  a_rcon_nonzero : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (init_i || adv_i) |=> rcon_o != 8'h00);

endmodule

//--- rtl/aes_key_round_cnt.sv
// Counter of completed expansion steps
// Flags the last step for the current key length

`timescale 1ns/1ps
`include "aes_key_consts.svh"

module aes_key_round_cnt (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  logic                    inc_i,
  input  aes_key_pkg::key_len_e   key_len_i,
  output logic [`AES_ROUND_W-1:0] round_o,
  output logic                    last_o
);

  logic [`AES_ROUND_W-1:0] round_q;
  logic [`AES_ROUND_W-1:0] limit;

  // Step limit, AES-128 for anything else
  assign limit = (key_len_i == aes_key_pkg::AES_256) ? `AES_ROUND_W'(`AES_STEPS_256) :
                                                       `AES_ROUND_W'(`AES_STEPS_128);

  // Clear wins, a restart may coincide with a step request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      round_q <= '0;
    end else if (clear_i) begin
      round_q <= '0;
    end else if (inc_i) begin
      round_q <= round_q + 1'b1;
    end
  end

  assign round_o = round_q;
  assign last_o  = (round_q == limit);

  // Controller stops stepping at the limit
  a_round_in_range : assert property (@(posedge clk_i) disable iff (!rst_ni)
    round_q <= limit);

endmodule

//--- rtl/aes_key_ctrl.sv
// Idle/active FSM of the key schedule
// Issues load, step and Rcon-advance strobes and the RotWord/Rcon use level

`timescale 1ns/1ps

module aes_key_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  start_i,
  input  logic                  next_i,
  input  aes_key_pkg::key_len_e key_len_i,
  input  logic                  round_lsb_i,
  input  logic                  last_i,
  output logic                  load_o,
  output logic                  step_o,
  output logic                  rcon_adv_o,
  output logic                  full_step_o,
  output logic                  key_valid_o
);

  aes_key_pkg::key_ctrl_state_e state_q, state_d;

  ////////////////////
  // State machine
  ////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      aes_key_pkg::KEY_IDLE: begin
        if (start_i) begin
          state_d = aes_key_pkg::KEY_ACTIVE;
        end
      end
      aes_key_pkg::KEY_ACTIVE: begin
        // Next at the limit ends the run, start restarts it
        if (!start_i && next_i && last_i) begin
          state_d = aes_key_pkg::KEY_IDLE;
        end
      end
      default: state_d = aes_key_pkg::KEY_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= aes_key_pkg::KEY_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////
  // Strobes
  ////////////////////

  assign key_valid_o = (state_q == aes_key_pkg::KEY_ACTIVE);
  assign load_o      = start_i;
  // Start wins over next
  assign step_o      = next_i & key_valid_o & ~last_i & ~start_i;

  // AES-256 alternates full and SubWord-only steps, even rounds are full
  assign full_step_o = (key_len_i == aes_key_pkg::AES_128) | ~round_lsb_i;
  assign rcon_adv_o  = step_o & full_step_o;

  // Every AES-256 step flips between full and SubWord-only
  a_full_step_alt : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (step_o && key_len_i == aes_key_pkg::AES_256) |=> full_step_o != $past(full_step_o));

endmodule

//--- rtl/aes_key_word_mix.sv
// Combinational next-window logic for one key expansion step
// RotWord/SubWord/Rcon on one word, then the XOR chains per direction and length

`timescale 1ns/1ps
`include "aes_key_consts.svh"

module aes_key_word_mix (
  input  aes_key_pkg::ciph_op_e                       op_i,
  input  aes_key_pkg::key_len_e                       key_len_i,
  input  logic                                        full_step_i,
  input  logic [7:0]                                  rcon_i,
  input  logic [`AES_KEY_WORDS-1:0][`AES_WORD_W-1:0]  key_i,
  output logic [`AES_KEY_WORDS-1:0][`AES_WORD_W-1:0]  key_o
);

  logic [`AES_WORD_W-1:0] rot_in;
  logic [`AES_WORD_W-1:0] rot_out;
  logic [3:0][7:0]        sbox_byte;

  aes_key_pkg::key_word_u sub_in;
  aes_key_pkg::key_word_u sub_out;
  aes_key_pkg::key_word_u irregular;

  ////////////////////
  // Irregular word
  ////////////////////

  // Source word of RotWord, see FIPS-197 inverse derivation for AES-128
  always_comb begin
    unique case (key_len_i)
      aes_key_pkg::AES_256: begin
        rot_in = (op_i == aes_key_pkg::CIPH_FWD) ? key_i[7] : key_i[3];
      end
      default: begin
        // Inverse AES-128 rebuilds old word 3 from the two upper words
        rot_in = (op_i == aes_key_pkg::CIPH_FWD) ? key_i[3] : (key_i[3] ^ key_i[2]);
      end
    endcase
  end

  // First byte moves to the end
  assign rot_out  = {rot_in[23:0], rot_in[31:24]};
  assign sub_in.w = full_step_i ? rot_out : rot_in;

  for (genvar i = 0; i < 4; i++) begin : gen_sbox
    aes_sbox_lut u_sbox (
      .data_i ( sub_in.b[i]  ),
      .data_o ( sbox_byte[i] )
    );
  end

  assign sub_out.b = sbox_byte;

  // Rcon goes into the FIPS first byte on full steps
  always_comb begin
    irregular = sub_out;
    if (full_step_i) begin
      irregular.b[3] = sub_out.b[3] ^ rcon_i;
    end
  end

  ////////////////////
  // XOR chains
  ////////////////////

  always_comb begin
    key_o = key_i;
    unique case (key_len_i)
      aes_key_pkg::AES_256: begin
        if (op_i == aes_key_pkg::CIPH_FWD) begin
          // Upper half moves down, new upper half from the old lower half
          key_o[3:0] = key_i[7:4];
          key_o[4]   = irregular.w ^ key_i[0];
          for (int i = 1; i < 4; i++) begin
            key_o[i+4] = key_o[i+3] ^ key_i[i];
          end
        end else begin
          // Lower half moves up, new lower half from adjacent upper words
          key_o[7:4] = key_i[3:0];
          key_o[0]   = irregular.w ^ key_i[4];
          for (int i = 1; i < 4; i++) begin
            key_o[i] = key_i[i+4] ^ key_i[i+3];
          end
        end
      end
      default: begin
        // AES-128, words 7..4 hold their value
        key_o[0] = irregular.w ^ key_i[0];
        if (op_i == aes_key_pkg::CIPH_FWD) begin
          for (int i = 1; i < 4; i++) begin
            key_o[i] = key_o[i-1] ^ key_i[i];
          end
        end else begin
          for (int i = 1; i < 4; i++) begin
            key_o[i] = key_i[i-1] ^ key_i[i];
          end
        end
      end
    endcase
  end

endmodule

//--- rtl/aes_key_expand.sv
// Top level of the AES-128/256 key schedule engine
// Key window register, registered op and key length, submodule wiring

`timescale 1ns/1ps
`include "aes_key_consts.svh"

module aes_key_expand (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  logic                                       start_i,
  input  logic                                       next_i,
  input  aes_key_pkg::ciph_op_e                      op_i,
  input  aes_key_pkg::key_len_e                      key_len_i,
  input  logic [`AES_KEY_WORDS-1:0][`AES_WORD_W-1:0] key_i,
  output logic [`AES_KEY_WORDS-1:0][`AES_WORD_W-1:0] key_o,
  output logic [`AES_ROUND_W-1:0]                    round_o,
  output logic                                       key_valid_o
);

  // Run configuration, sampled at start
  aes_key_pkg::ciph_op_e op_q;
  aes_key_pkg::key_len_e key_len_q;

  logic [`AES_KEY_WORDS-1:0][`AES_WORD_W-1:0] key_q;
  logic [`AES_KEY_WORDS-1:0][`AES_WORD_W-1:0] key_next;

  logic       load;
  logic       step;
  logic       rcon_adv;
  logic       full_step;
  logic       last;
  logic [7:0] rcon;

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      op_q      <= aes_key_pkg::CIPH_FWD;
      key_len_q <= aes_key_pkg::AES_128;
    end else if (load) begin
      op_q      <= op_i;
      key_len_q <= key_len_i;
    end
  end

  // Key window, holds while no step is requested
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q <= '0;
    end else if (load) begin
      key_q <= key_i;
    end else if (step) begin
      key_q <= key_next;
    end
  end

  assign key_o = key_q;

  ////////////////////
  // Submodules
  ////////////////////

  aes_key_ctrl u_ctrl (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .start_i     ( start_i     ),
    .next_i      ( next_i      ),
    .key_len_i   ( key_len_q   ),
    .round_lsb_i ( round_o[0]  ),
    .last_i      ( last        ),
    .load_o      ( load        ),
    .step_o      ( step        ),
    .rcon_adv_o  ( rcon_adv    ),
    .full_step_o ( full_step   ),
    .key_valid_o ( key_valid_o )
  );

  aes_key_round_cnt u_round_cnt (
    .clk_i     ( clk_i     ),
    .rst_ni    ( rst_ni    ),
    .clear_i   ( load      ),
    .inc_i     ( step      ),
    .key_len_i ( key_len_q ),
    .round_o   ( round_o   ),
    .last_o    ( last      )
  );

  // Start value depends on the incoming configuration, not the held one
  aes_rcon_gen u_rcon_gen (
    .clk_i     ( clk_i                  ),
    .rst_ni    ( rst_ni                 ),
    .init_i    ( load                   ),
    .adv_i     ( rcon_adv               ),
    .op_i      ( load ? op_i : op_q     ),
    .key_len_i ( load ? key_len_i : key_len_q ),
    .rcon_o    ( rcon                   )
  );

  aes_key_word_mix u_word_mix (
    .op_i        ( op_q      ),
    .key_len_i   ( key_len_q ),
    .full_step_i ( full_step ),
    .rcon_i      ( rcon      ),
    .key_i       ( key_q     ),
    .key_o       ( key_next  )
  );

  // Only the two supported key lengths may start a run
  a_key_len_valid : assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_i |-> key_len_i inside {aes_key_pkg::AES_128, aes_key_pkg::AES_256});

endmodule

//--- tb/tb_aes_key_expand.sv
// Directed testbench of the AES-128/256 key schedule engine
// Reference FIPS-197 schedule built from its own GF(2^8) S-Box and Rcon
// Tests for reset, FIPS vectors, random round trips and restart

`timescale 1ns/1ps
`include "aes_key_consts.svh"

module tb_aes_key_expand;

  // 2000 cycles covers eight runs of up to 14 steps with gaps of up to 8, plus margin
  localparam int TIMEOUT_CYCLES = 2000;

  logic                                       clk_i;
  logic                                       rst_ni;
  logic                                       start_i;
  logic                                       next_i;
  aes_key_pkg::ciph_op_e                      op_i;
  aes_key_pkg::key_len_e                      key_len_i;
  logic [`AES_KEY_WORDS-1:0][`AES_WORD_W-1:0] key_i;
  logic [`AES_KEY_WORDS-1:0][`AES_WORD_W-1:0] key_o;
  logic [`AES_ROUND_W-1:0]                    round_o;
  logic                                       key_valid_o;

  // Full reference schedule, 44 or 60 words
  logic [31:0] sched [0:59];

  int err_cnt   = 0;
  int check_cnt = 0;
  int test_cnt  = 0;
  int cycle_cnt = 0;
  int seed      = 32'hdb2020ec;

  aes_key_expand u_dut (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .start_i     ( start_i     ),
    .next_i      ( next_i      ),
    .op_i        ( op_i        ),
    .key_len_i   ( key_len_i   ),
    .key_i       ( key_i       ),
    .key_o       ( key_o       ),
    .round_o     ( round_o     ),
    .key_valid_o ( key_valid_o )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  initial begin
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    $display("Run hung, no end after %0d cycles", cycle_cnt);
    $display("Simulation failed");
    $finish;
  end

  ////////////////////
  // Reference model
  ////////////////////

  function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] x;
    p = 8'h00;
    x = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) p ^= x;
      x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
    end
    return p;
  endfunction

  // Multiplicative inverse as a^254, then the FIPS-197 affine map
  function automatic logic [7:0] sbox_ref(input logic [7:0] a);
    logic [7:0] inv;
    logic [7:0] s;
    inv = 8'h01;
    repeat (254) inv = gf_mul(inv, a);
    s = inv ^ 8'h63;
    for (int k = 1; k < 5; k++) begin
      s ^= (inv << k) | (inv >> (8 - k));
    end
    return s;
  endfunction

  function automatic logic [31:0] sub_word(input logic [31:0] w);
    return {sbox_ref(w[31:24]), sbox_ref(w[23:16]), sbox_ref(w[15:8]), sbox_ref(w[7:0])};
  endfunction

  // Rcon for schedule index i/Nk, starting at 01
  function automatic logic [7:0] rcon_ref(input int idx);
    logic [7:0] rc;
    rc = 8'h01;
    repeat (idx - 1) rc = gf_mul(rc, 8'h02);
    return rc;
  endfunction

  task automatic build_schedule(input logic [7:0][31:0] key, input bit is256);
    int nk;
    int nw;
    logic [31:0] t;
    nk = is256 ? 8 : 4;
    nw = is256 ? 60 : 44;
    for (int i = 0; i < nk; i++) sched[i] = key[i];
    for (int i = nk; i < nw; i++) begin
      t = sched[i-1];
      if (i % nk == 0) begin
        t = sub_word({t[23:0], t[31:24]}) ^ {rcon_ref(i / nk), 24'h0};
      end else if (nk == 8 && i % nk == 4) begin
        t = sub_word(t);
      end
      sched[i] = sched[i-nk] ^ t;
    end
  endtask

  // Expected window, schedule word base lands in window word 0
  function automatic logic [255:0] window_at(input int base, input int n);
    logic [7:0][31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v[i] = sched[base+i];
    return v;
  endfunction

  // AES-128 only defines words 0..3
  function automatic logic [255:0] window_of(input logic [7:0][31:0] k, input int n);
    return (n == 8) ? k : {128'h0, k[3:0]};
  endfunction

  ////////////////////
  // Drivers and checks
  ////////////////////

  task automatic check_value(input string name, input logic [255:0] exp, input logic [255:0] act);
    check_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("CHECK FAILED %s: expected %h, got %h", name, exp, act);
    end
  endtask

  task automatic report_test(input string name, input int err_start);
    test_cnt++;
    $display("%s finished, %0d errors", name, err_cnt - err_start);
  endtask

  task automatic drive_start(input aes_key_pkg::ciph_op_e op, input bit is256,
                             input logic [7:0][31:0] key);
    @(posedge clk_i);
    start_i   <= 1'b1;
    op_i      <= op;
    key_len_i <= is256 ? aes_key_pkg::AES_256 : aes_key_pkg::AES_128;
    key_i     <= key;
    @(posedge clk_i);
    start_i <= 1'b0;
    @(negedge clk_i);
  endtask

  task automatic drive_next();
    @(posedge clk_i);
    next_i <= 1'b1;
    @(posedge clk_i);
    next_i <= 1'b0;
    @(negedge clk_i);
  endtask

  // One whole run, every window checked against sched, then the final next
  task automatic run_expansion(input aes_key_pkg::ciph_op_e op, input bit is256,
                               input logic [7:0][31:0] start_key, input int max_gap,
                               output logic [7:0][31:0] final_key);
    int steps;
    int nwin;
    int base;
    int gap;
    steps = is256 ? `AES_STEPS_256 : `AES_STEPS_128;
    nwin  = is256 ? 8 : 4;
    drive_start(op, is256, start_key);
    for (int r = 0; r <= steps; r++) begin
      base = (op == aes_key_pkg::CIPH_FWD) ? 4 * r : 4 * (steps - r);
      check_value("key_valid_o", 1, key_valid_o);
      check_value("round_o", r, round_o);
      check_value($sformatf("key_o step %0d", r), window_at(base, nwin),
                  window_of(key_o, nwin));
      gap = (max_gap > 0) ? {$random(seed)} % (max_gap + 1) : 0;
      // Window and count hold while next stays low
      repeat (gap) begin
        @(negedge clk_i);
        check_value("key_o in gap", window_at(base, nwin), window_of(key_o, nwin));
        check_value("round_o in gap", r, round_o);
      end
      if (r < steps) drive_next();
    end
    final_key = key_o;
    drive_next();
    check_value("key_valid_o after limit", 0, key_valid_o);
    check_value("round_o after limit", steps, round_o);
    check_value("key_o after limit", window_at(base, nwin), window_of(key_o, nwin));
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic reset_defaults();
    int err_start;
    err_start = err_cnt;
    check_value("key_valid_o", 0, key_valid_o);
    check_value("key_o", 0, key_o);
    check_value("round_o", 0, round_o);
    report_test("reset", err_start);
  endtask

  task automatic fips128_vectors();
    int err_start;
    logic [7:0][31:0] key;
    logic [7:0][31:0] fin;
    err_start = err_cnt;
    key = {128'h0, 32'h09cf4f3c, 32'habf71588, 32'h28aed2a6, 32'h2b7e1516};
    build_schedule(key, 1'b0);
    run_expansion(aes_key_pkg::CIPH_FWD, 1'b0, key, 0, fin);
    // Last round key as printed in FIPS-197 appendix A.1
    check_value("key_o round 10", 128'hb6630ca6_e13f0cc8_c9ee2589_d014f9a8, fin[3:0]);
    report_test("aes128 forward", err_start);
    err_start = err_cnt;
    run_expansion(aes_key_pkg::CIPH_INV, 1'b0, window_at(40, 4), 0, fin);
    check_value("key_o back to cipher key", window_of(key, 4), window_of(fin, 4));
    report_test("aes128 inverse", err_start);
  endtask

  task automatic fips256_vectors();
    int err_start;
    logic [7:0][31:0] key;
    logic [7:0][31:0] fin;
    err_start = err_cnt;
    key = {32'h0914dff4, 32'h2d9810a3, 32'h3b6108d7, 32'h1f352c07,
           32'h857d7781, 32'h2b73aef0, 32'h15ca71be, 32'h603deb10};
    build_schedule(key, 1'b1);
    run_expansion(aes_key_pkg::CIPH_FWD, 1'b1, key, 0, fin);
    run_expansion(aes_key_pkg::CIPH_INV, 1'b1, window_at(52, 8), 0, fin);
    check_value("key_o back to cipher key", key, fin);
    report_test("aes256 forward and inverse", err_start);
  endtask

  // Forward then inverse from the DUT's own last window
  task automatic random_roundtrip();
    int err_start;
    logic [7:0][31:0] key;
    logic [7:0][31:0] fwd_fin;
    logic [7:0][31:0] inv_fin;
    err_start = err_cnt;
    for (int len = 0; len < 2; len++) begin
      for (int i = 0; i < 8; i++) key[i] = $random(seed);
      build_schedule(key, len[0]);
      run_expansion(aes_key_pkg::CIPH_FWD, len[0], key, 8, fwd_fin);
      run_expansion(aes_key_pkg::CIPH_INV, len[0], fwd_fin, 8, inv_fin);
      check_value("key_o round trip", window_of(key, len ? 8 : 4),
                  window_of(inv_fin, len ? 8 : 4));
    end
    report_test("random round trip", err_start);
  endtask

  task automatic restart_mid_run();
    int err_start;
    logic [7:0][31:0] key_a;
    logic [7:0][31:0] key_b;
    err_start = err_cnt;
    for (int i = 0; i < 8; i++) key_a[i] = $random(seed);
    for (int i = 0; i < 8; i++) key_b[i] = $random(seed);
    drive_start(aes_key_pkg::CIPH_FWD, 1'b1, key_a);
    repeat (3) drive_next();
    // Start and next together, start wins
    @(posedge clk_i);
    start_i   <= 1'b1;
    next_i    <= 1'b1;
    op_i      <= aes_key_pkg::CIPH_FWD;
    key_len_i <= aes_key_pkg::AES_128;
    key_i     <= key_b;
    @(posedge clk_i);
    start_i <= 1'b0;
    next_i  <= 1'b0;
    @(negedge clk_i);
    check_value("round_o after restart", 0, round_o);
    check_value("key_o after restart", key_b, key_o);
    check_value("key_valid_o after restart", 1, key_valid_o);
    build_schedule(key_b, 1'b0);
    drive_next();
    check_value("round_o step 1", 1, round_o);
    check_value("key_o step 1", window_at(4, 4), window_of(key_o, 4));
    report_test("restart", err_start);
  endtask

  initial begin
    rst_ni    = 1'b0;
    start_i   = 1'b0;
    next_i    = 1'b0;
    op_i      = aes_key_pkg::CIPH_FWD;
    key_len_i = aes_key_pkg::AES_128;
    key_i     = '0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    reset_defaults();
    fips128_vectors();
    fips256_vectors();
    random_roundtrip();
    restart_mid_run();
    $display("Tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- aes_key_expand.f
+incdir+include
rtl/aes_key_pkg.sv
rtl/aes_sbox_lut.sv
rtl/aes_rcon_gen.sv
rtl/aes_key_round_cnt.sv
rtl/aes_key_ctrl.sv
rtl/aes_key_word_mix.sv
rtl/aes_key_expand.sv
tb/tb_aes_key_expand.sv

//--- Bender.yml
package:
  name: aes_key_expand

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/aes_key_pkg.sv
      - rtl/aes_sbox_lut.sv
      - rtl/aes_rcon_gen.sv
      - rtl/aes_key_round_cnt.sv
      - rtl/aes_key_ctrl.sv
      - rtl/aes_key_word_mix.sv
      - rtl/aes_key_expand.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_aes_key_expand.sv
